//--- hw/turbo_pkg.sv
// shared types for the turbo and timebase block
// width typedefs, turbo speed enum and settings struct
// AXI4-Lite request and response structs, register offsets

package turbo_pkg;

  typedef logic [15:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [11:0] div_count_t;
  typedef logic [19:0] suppress_count_t;
  typedef logic [14:0] audio_sample_t;

  typedef enum logic [1:0] {
    speed_1x   = 2'd0,
    speed_4x   = 2'd1,
    speed_50x  = 2'd2,
    speed_full = 2'd3
  } turbo_speed_e;

  typedef struct packed {
    turbo_speed_e speed;
    logic         cancel_on_event;
    logic         suppress_after_activation;
    logic         disable_sound;
  } turbo_cfg_t;

  // manager side of the bus
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // subordinate side of the bus
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  localparam axil_addr_t reg_sound_addr    = 16'h0010;
  localparam axil_addr_t reg_speed_addr    = 16'h0100;
  localparam axil_addr_t reg_cancel_addr   = 16'h0104;
  localparam axil_addr_t reg_suppress_addr = 16'h0108;

  // buzzer high level, thirteen ones
  localparam audio_sample_t audio_on_level = 15'h1FFF;

endpackage

//--- hw/turbo_regs.sv
// AXI4-Lite register block for the turbo settings
// speed, cancel on event, suppress after activation, disable sound
// speed field is cleared by the governor's cancel request

`timescale 1ns/1ps

module turbo_regs
  import turbo_pkg::*;
(
  input  logic       clk_sys_117_964,
  input  logic       reset_turbo_s,
  input  axil_req_t  axil_req,
  input  logic       turbo_cancel,
  output axil_rsp_t  axil_rsp,
  output turbo_cfg_t cfg
);

  turbo_cfg_t cfg_q;

  logic       bvalid_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_data_t rd_word;

  logic wr_fire;
  logic rd_fire;

  ////////////////////////////////////////////////////////////
  // handshakes

  // address and data accepted together, one write in flight
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;

  // one read in flight, response held under back-pressure
  assign rd_fire = axil_req.arvalid && !rvalid_q;

  ////////////////////////////////////////////////////////////
  // register writes

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      cfg_q    <= '0;
      bvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end

      // only the low byte carries settings
      if (wr_fire && axil_req.wstrb[0]) begin
        case (axil_req.awaddr)
          reg_sound_addr: begin
            cfg_q.disable_sound <= axil_req.wdata[0];
          end
          reg_speed_addr: begin
            cfg_q.speed <= turbo_speed_e'(axil_req.wdata[1:0]);
          end
          reg_cancel_addr: begin
            cfg_q.cancel_on_event <= axil_req.wdata[0];
          end
          reg_suppress_addr: begin
            cfg_q.suppress_after_activation <= axil_req.wdata[0];
          end
          default: begin
            // unmapped, dropped
          end
        endcase
      end

      // cancel wins over a write in the same cycle
      if (turbo_cancel) begin
        cfg_q.speed <= speed_1x;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // register reads

  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      reg_sound_addr: begin
        rd_word[0] = cfg_q.disable_sound;
      end
      reg_speed_addr: begin
        rd_word[1:0] = cfg_q.speed;
      end
      reg_cancel_addr: begin
        rd_word[0] = cfg_q.cancel_on_event;
      end
      reg_suppress_addr: begin
        rd_word[0] = cfg_q.suppress_after_activation;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // read payload, captured with the address
  always_ff @(posedge clk_sys_117_964) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // response side

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = bvalid_q;
    // always OKAY
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = 2'b00;
  end

  assign cfg = cfg_q;

endmodule

//--- hw/core_clock_div.sv
// core timebase divider
// reload picked from the turbo speed, half-way point latched at reload
// produces the core tick and the double-rate tick

`timescale 1ns/1ps

module core_clock_div
  import turbo_pkg::*;
#(
  parameter int base_div = 3600
) (
  input  logic       clk_sys_117_964,
  input  logic       reset_turbo_s,
  input  turbo_cfg_t cfg,
  input  logic       halt,
  output logic       clk_en,
  output logic       clk_2x_en
);

  div_count_t reload_value;
  div_count_t half_value;
  div_count_t count_q;
  div_count_t half_q;

  // reload per speed
  always_comb begin
    case (cfg.speed)
      speed_1x:  reload_value = div_count_t'(base_div);
      speed_4x:  reload_value = div_count_t'(base_div / 4);
      speed_50x: reload_value = div_count_t'(base_div / 50);
      default:   reload_value = div_count_t'(1);
    endcase
  end

  // full speed keeps the half point at 1 so the 2x tick still fires
  assign half_value = (reload_value == div_count_t'(1)) ? div_count_t'(1) :
                      (reload_value >> 1);

  ////////////////////////////////////////////////////////////
  // down counter and tick enables

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      count_q   <= '0;
      half_q    <= '0;
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;

      // halt freezes everything
      if (!halt) begin
        if (count_q == '0) begin
          count_q   <= reload_value;
          // latched so a speed change mid-period cannot skip a half tick
          half_q    <= half_value;
          clk_en    <= 1'b1;
          clk_2x_en <= 1'b1;
        end else begin
          count_q <= count_q - div_count_t'(1);
          if (count_q == half_q) begin
            clk_2x_en <= 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- hw/turbo_governor.sv
// turbo governor
// activation detect, suppression window in core ticks
// cancel request on halt or buzzer event, buzzer sample muting

`timescale 1ns/1ps

module turbo_governor
  import turbo_pkg::*;
#(
  parameter int suppress_ticks = 163840
) (
  input  logic          clk_sys_117_964,
  input  logic          reset_turbo_s,
  input  turbo_cfg_t    cfg,
  input  logic          clk_en,
  input  logic          buzzer,
  input  logic          halt,
  output logic          turbo_cancel,
  output audio_sample_t audio_sample
);

  localparam suppress_count_t window_len = suppress_count_t'(suppress_ticks);

  turbo_speed_e    prev_speed_q;
  suppress_count_t window_q;
  suppress_count_t window_start;
  suppress_count_t window_next;

  logic activated;
  logic turbo_on;
  logic buzzer_event;
  logic cancel_req;
  logic sound_on;

  ////////////////////////////////////////////////////////////
  // activation and suppression window

  assign turbo_on  = (cfg.speed != speed_1x);
  assign activated = turbo_on && (prev_speed_q == speed_1x);

  always_comb begin
    window_start = window_q;
    // fresh window when turbo switches on
    if (activated && cfg.suppress_after_activation) begin
      window_start = window_len;
    end

    window_next = window_start;
    // counts in core time, not system clocks
    if (clk_en && window_start != '0) begin
      window_next = window_start - suppress_count_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // cancel request

  // buzzer only cancels a running turbo outside the window
  assign buzzer_event = buzzer && cfg.cancel_on_event && turbo_on &&
                        (window_start == '0);
  assign cancel_req   = halt || buzzer_event;

  // muted when disabled or at 50x and above
  assign sound_on = buzzer && !cfg.disable_sound && (cfg.speed < speed_50x);

  always_ff @(posedge clk_sys_117_964) begin
    if (reset_turbo_s) begin
      prev_speed_q <= speed_1x;
      window_q     <= '0;
      turbo_cancel <= 1'b0;
      audio_sample <= '0;
    end else begin
      prev_speed_q <= cfg.speed;
      window_q     <= window_next;
      turbo_cancel <= cancel_req;
      audio_sample <= sound_on ? audio_on_level : '0;
    end
  end

endmodule

//--- hw/tama_turbo_top.sv
// turbo and timebase top level
// register block, core clock divider and turbo governor

`timescale 1ns/1ps

module tama_turbo_top
  import turbo_pkg::*;
#(
  parameter int base_div       = 3600,
  parameter int suppress_ticks = 163840
) (
  input  logic          clk_sys_117_964,
  input  logic          reset_turbo_s,
  input  axil_req_t     axil_req,
  input  logic          buzzer,
  input  logic          halt,
  output axil_rsp_t     axil_rsp,
  output logic          clk_en,
  output logic          clk_2x_en,
  output audio_sample_t audio_sample
);

  turbo_cfg_t cfg;
  logic       turbo_cancel;

  ////////////////////////////////////////////////////////////
  // settings registers

  turbo_regs u_regs (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .axil_req        (axil_req),
    .turbo_cancel    (turbo_cancel),
    .axil_rsp        (axil_rsp),
    .cfg             (cfg)
  );

  ////////////////////////////////////////////////////////////
  // core timebase

  core_clock_div #(
    .base_div (base_div)
  ) u_clock_div (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .cfg             (cfg),
    .halt            (halt),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en)
  );

  ////////////////////////////////////////////////////////////
  // turbo cancel and audio

  turbo_governor #(
    .suppress_ticks (suppress_ticks)
  ) u_governor (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .cfg             (cfg),
    .clk_en          (clk_en),
    .buzzer          (buzzer),
    .halt            (halt),
    .turbo_cancel    (turbo_cancel),
    .audio_sample    (audio_sample)
  );

endmodule

//--- tests/tb_clock_gen.sv
// testbench clock and reset source
// 20 ns clock, synchronous active-high reset for a set number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 5
) (
  output logic clk_sys_117_964,
  output logic reset_turbo_s
);

  initial begin
    clk_sys_117_964 = 1'b0;
    forever #(half_period) clk_sys_117_964 = ~clk_sys_117_964;
  end

  // released on a rising edge, like any other driven input
  initial begin
    reset_turbo_s = 1'b1;
    repeat (reset_cycles) @(posedge clk_sys_117_964);
    reset_turbo_s <= 1'b0;
  end

endmodule

//--- tests/tb_tama_turbo.sv
// testbench for the turbo and timebase top level
// AXI4-Lite write and read tasks, tick and pulse waits with timeouts
// register, divider, halt, cancel, suppression and audio tests

`timescale 1ns/1ps

module tb_tama_turbo
  import turbo_pkg::*;
;

  typedef struct packed {
    axil_addr_t addr;
    axil_data_t mask;
  } reg_case_t;

  typedef struct packed {
    logic          disable_sound;
    logic [1:0]    speed;
    logic          buzzer;
    audio_sample_t expected;
  } audio_case_t;

  // offset and the bits that read back
  localparam reg_case_t reg_table [8] = '{
    '{reg_sound_addr,    32'h1}, '{reg_speed_addr,    32'h3},
    '{reg_cancel_addr,   32'h1}, '{reg_suppress_addr, 32'h1},
    '{16'h0000, 32'h0}, '{16'h0014, 32'h0},
    '{16'h010C, 32'h0}, '{16'h0200, 32'h0}
  };

  // sound on only for buzzer high, not disabled, below 50x
  localparam audio_case_t audio_table [8] = '{
    '{1'b0, 2'd0, 1'b1, 15'h1FFF}, '{1'b0, 2'd1, 1'b1, 15'h1FFF},
    '{1'b0, 2'd2, 1'b1, 15'h0000}, '{1'b0, 2'd3, 1'b1, 15'h0000},
    '{1'b1, 2'd0, 1'b1, 15'h0000}, '{1'b1, 2'd1, 1'b1, 15'h0000},
    '{1'b0, 2'd0, 1'b0, 15'h0000}, '{1'b0, 2'd1, 1'b0, 15'h0000}
  };

  // reload + 1 with base_div 200
  localparam int tick_gaps [4] = '{201, 51, 5, 2};
  localparam int tick_limit = 1000;
  localparam int bus_limit  = 50;

  logic          clk_sys_117_964;
  logic          reset_turbo_s;
  axil_req_t     axil_req;
  axil_rsp_t     axil_rsp;
  logic          buzzer;
  logic          halt;
  logic          clk_en;
  logic          clk_2x_en;
  audio_sample_t audio_sample;

  axil_data_t rng_state;
  int errors;
  int checks;
  int tests;
  int failed_tests;
  int errors_at_start;

  tb_clock_gen #(.half_period(10), .reset_cycles(5)) u_clock_gen (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s)
  );

  tama_turbo_top #(.base_div(200), .suppress_ticks(6)) dut (
    .clk_sys_117_964 (clk_sys_117_964),
    .reset_turbo_s   (reset_turbo_s),
    .axil_req        (axil_req),
    .buzzer          (buzzer),
    .halt            (halt),
    .axil_rsp        (axil_rsp),
    .clk_en          (clk_en),
    .clk_2x_en       (clk_2x_en),
    .audio_sample    (audio_sample)
  );

  ////////////////////////////////////////////////////////////
  // helpers

  function automatic axil_data_t xorshift32(input axil_data_t x);
    axil_data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("error: t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("timeout at t=%0t while waiting for %s", $time, what);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic begin_test();
    errors_at_start = errors;
    tests++;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite manager

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    int cycles;
    cycles = 0;
    @(posedge clk_sys_117_964);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    @(negedge clk_sys_117_964);
    while (!axil_rsp.awready) begin
      cycles++;
      if (cycles > bus_limit) stop_on_timeout("awready");
      @(negedge clk_sys_117_964);
    end
    // address and data are accepted in the same cycle
    check_value("wready", 32'h1, 32'(axil_rsp.wready));
    @(posedge clk_sys_117_964);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    axil_req.bready  <= 1'b1;
    cycles = 0;
    @(negedge clk_sys_117_964);
    while (!axil_rsp.bvalid) begin
      cycles++;
      if (cycles > bus_limit) stop_on_timeout("bvalid");
      @(negedge clk_sys_117_964);
    end
    check_value("bresp", 32'h0, 32'(axil_rsp.bresp));
    @(posedge clk_sys_117_964);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    int cycles;
    cycles = 0;
    @(posedge clk_sys_117_964);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    @(negedge clk_sys_117_964);
    while (!axil_rsp.arready) begin
      cycles++;
      if (cycles > bus_limit) stop_on_timeout("arready");
      @(negedge clk_sys_117_964);
    end
    @(posedge clk_sys_117_964);
    axil_req.arvalid <= 1'b0;
    axil_req.rready  <= 1'b1;
    cycles = 0;
    @(negedge clk_sys_117_964);
    while (!axil_rsp.rvalid) begin
      cycles++;
      if (cycles > bus_limit) stop_on_timeout("rvalid");
      @(negedge clk_sys_117_964);
    end
    data = axil_rsp.rdata;
    check_value("rresp", 32'h0, 32'(axil_rsp.rresp));
    @(posedge clk_sys_117_964);
    axil_req.rready <= 1'b0;
  endtask

  task automatic clear_settings();
    axil_write(reg_sound_addr, 32'h0);
    axil_write(reg_speed_addr, 32'h0);
    axil_write(reg_cancel_addr, 32'h0);
    axil_write(reg_suppress_addr, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // tick waits

  task automatic wait_clk_en();
    int cycles;
    cycles = 0;
    @(negedge clk_sys_117_964);
    while (!clk_en) begin
      cycles++;
      if (cycles > tick_limit) stop_on_timeout("clk_en");
      @(negedge clk_sys_117_964);
    end
  endtask

  // cycles to the next clk_en, and 2x-only pulses on the way
  task automatic measure_gap(output int gap, output int halves);
    gap = 0;
    halves = 0;
    do begin
      @(negedge clk_sys_117_964);
      gap++;
      if (clk_2x_en && !clk_en) halves++;
      if (gap > tick_limit) stop_on_timeout("next clk_en");
    end while (!clk_en);
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic register_readback();
    axil_data_t rd;
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      axil_write(reg_table[i].addr, rng_state);
      axil_read(reg_table[i].addr, rd);
      check_value($sformatf("rdata at 0x%0h", reg_table[i].addr),
                  rng_state & reg_table[i].mask, rd);
    end
  endtask

  task automatic tick_spacing();
    int gap;
    int halves;
    for (int s = 0; s < 4; s++) begin
      axil_write(reg_speed_addr, axil_data_t'(s));
      wait_clk_en();
      wait_clk_en();
      measure_gap(gap, halves);
      check_value($sformatf("clk_en spacing at speed %0d", s), 32'(tick_gaps[s]), 32'(gap));
      if (s == 0) check_value("clk_2x_en between ticks", 32'd1, 32'(halves));
    end
    axil_write(reg_speed_addr, 32'h0);
  endtask

  task automatic halt_freeze();
    axil_data_t rd;
    int seen;
    seen = 0;
    axil_write(reg_speed_addr, 32'h2);
    @(posedge clk_sys_117_964);
    halt <= 1'b1;
    for (int i = 0; i < 500; i++) begin
      @(negedge clk_sys_117_964);
      // registered tick, the first cycle may still carry the last one
      if (i > 0 && clk_en) seen++;
    end
    @(posedge clk_sys_117_964);
    halt <= 1'b0;
    check_value("clk_en pulses during halt", 32'd0, 32'(seen));
    axil_read(reg_speed_addr, rd);
    check_value("speed after halt", 32'h0, rd);
  endtask

  task automatic buzzer_cancel();
    axil_data_t rd;
    clear_settings();
    axil_write(reg_cancel_addr, 32'h1);
    axil_write(reg_speed_addr, 32'h2);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    repeat (10) @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    axil_read(reg_speed_addr, rd);
    check_value("speed after buzzer, cancel on", 32'h0, rd);
    axil_write(reg_cancel_addr, 32'h0);
    axil_write(reg_speed_addr, 32'h2);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    repeat (10) @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    axil_read(reg_speed_addr, rd);
    check_value("speed after buzzer, cancel off", 32'h2, rd);
  endtask

  task automatic suppression_window();
    axil_data_t rd;
    clear_settings();
    axil_write(reg_suppress_addr, 32'h1);
    axil_write(reg_cancel_addr, 32'h1);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b1;
    // window of 6 core ticks starts here
    axil_write(reg_speed_addr, 32'h1);
    repeat (4) wait_clk_en();
    axil_read(reg_speed_addr, rd);
    check_value("speed inside window", 32'h1, rd);
    repeat (4) wait_clk_en();
    axil_read(reg_speed_addr, rd);
    check_value("speed after window", 32'h0, rd);
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
  endtask

  task automatic audio_muting();
    clear_settings();
    for (int i = 0; i < 8; i++) begin
      axil_write(reg_sound_addr, 32'(audio_table[i].disable_sound));
      axil_write(reg_speed_addr, 32'(audio_table[i].speed));
      @(posedge clk_sys_117_964);
      buzzer <= audio_table[i].buzzer;
      repeat (2) @(posedge clk_sys_117_964);
      @(negedge clk_sys_117_964);
      check_value($sformatf("audio_sample row %0d", i),
                  32'(audio_table[i].expected), 32'(audio_sample));
    end
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int cycles;
    axil_req     = '0;
    buzzer       = 1'b0;
    halt         = 1'b0;
    rng_state    = 32'd97;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    cycles       = 0;
    @(negedge clk_sys_117_964);
    while (reset_turbo_s) begin
      cycles++;
      if (cycles > 100) stop_on_timeout("reset release");
      @(negedge clk_sys_117_964);
    end

    begin_test();
    register_readback();
    end_test("register read-back");
    clear_settings();

    begin_test();
    tick_spacing();
    end_test("tick spacing");

    begin_test();
    halt_freeze();
    end_test("halt");

    begin_test();
    buzzer_cancel();
    end_test("buzzer cancel");

    begin_test();
    suppression_window();
    end_test("suppression window");

    begin_test();
    audio_muting();
    end_test("audio muting");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/turbo_pkg.sv
hw/turbo_regs.sv
hw/core_clock_div.sv
hw/turbo_governor.sv
hw/tama_turbo_top.sv
tests/tb_clock_gen.sv
tests/tb_tama_turbo.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_tama_turbo \
  -f vlog.f \
  -o sim_tama_turbo

status=0
./obj_dir/sim_tama_turbo > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit "$status"
